// File: hw/rv_pkg.sv
package rv_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int xlen       = 32;     // Data and address width
  localparam int reg_addr_w = 5;      // Register index width

  localparam logic [xlen-1:0] pc_step = 4;   // One word per fetch

  ////////////////////
  // Opcode map, inst[6:0]
  ////////////////////
  localparam logic [6:0] op_r       = 7'b0110011;
  localparam logic [6:0] op_i_arith = 7'b0010011;
  localparam logic [6:0] op_i_load  = 7'b0000011;
  localparam logic [6:0] op_s       = 7'b0100011;
  localparam logic [6:0] op_u_lui   = 7'b0110111;
  localparam logic [6:0] op_u_auipc = 7'b0010111;

  // ALU operations
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll
  } alu_op_e;

  // Decoded controls, all zero means no-op
  typedef struct packed {
    logic    regwrite;
    logic    memtoreg;   // Load, write-back takes memory data
    logic    memwrite;   // Store
    logic    alusrc;     // Second operand is the immediate
    logic    auipc;      // First operand is pc
    logic    lui;        // First operand is zero
    alu_op_e alu_op;
  } ctrl_t;

  ////////////////////
  // Pipeline registers
  ////////////////////
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       imm;        // Already selected I/S/U form
    ctrl_t                 ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       aluout;     // Also the data address
    logic [xlen-1:0]       store_data;
    logic                  regwrite;
    logic                  memtoreg;
    logic                  memwrite;
  } ex_mem_t;

  // Register file write port, also the write-back forwarding source
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } wb_t;

endpackage

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,   // Load-use hold from decode
  input  logic [rv_pkg::xlen-1:0] inst,
  output logic [rv_pkg::xlen-1:0] pc,
  output rv_pkg::if_id_t          if_id
);

  ////////////////////
  // PC and IF/ID
  ////////////////////
  // Cleared fetch register holds inst 0, which decodes as a no-op
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc    <= '0;
      if_id <= '0;
    end
    else if (!stall)
    begin
      pc    <= pc + rv_pkg::pc_step;   // Always sequential without branches
      if_id <= '{pc: pc, inst: inst};
    end
    // Stall keeps both for one more cycle
  end

  // Decode bubble clears the hazard so a hold lasts one cycle
  a_hold_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    stall |=> !stall
  ) else $error("load-use stall held for two cycles");

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic [rv_pkg::xlen-1:0] inst,
  output rv_pkg::ctrl_t           ctrl,
  output logic [rv_pkg::xlen-1:0] imm
);

  logic [6:0]              opcode;
  logic [6:0]              funct7;
  logic [2:0]              funct3;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_u;

  assign opcode = inst[6:0];
  assign funct7 = inst[31:25];
  assign funct3 = inst[14:12];

  // Sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};     // LUI / AUIPC

  always_comb
  begin
    ctrl = '0;     // Unknown opcode falls through as a no-op
    imm  = '0;
    case (opcode)
      rv_pkg::op_r:
      begin
        ctrl.regwrite = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = rv_pkg::alu_add;
          10'b0100000_000: ctrl.alu_op = rv_pkg::alu_sub;
          10'b0000000_111: ctrl.alu_op = rv_pkg::alu_and;
          10'b0000000_110: ctrl.alu_op = rv_pkg::alu_or;
          default:         ctrl.regwrite = 1'b0;   // Unsupported funct
        endcase
      end
      rv_pkg::op_i_arith:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        imm           = imm_i;
        case (funct3)
          3'b000:  ctrl.alu_op = rv_pkg::alu_add;   // ADDI
          3'b100:  ctrl.alu_op = rv_pkg::alu_xor;   // XORI
          3'b110:  ctrl.alu_op = rv_pkg::alu_or;    // ORI
          3'b111:  ctrl.alu_op = rv_pkg::alu_and;   // ANDI
          3'b001:
          begin
            ctrl.alu_op   = rv_pkg::alu_sll;        // SLLI, shamt in imm[4:0]
            ctrl.regwrite = (funct7 == 7'b0000000);
          end
          default: ctrl.regwrite = 1'b0;
        endcase
      end
      rv_pkg::op_i_load:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.memtoreg = 1'b1;
        ctrl.alusrc   = 1'b1;
        imm           = imm_i;                      // Address offset
      end
      rv_pkg::op_s:
      begin
        ctrl.memwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        imm           = imm_s;
      end
      rv_pkg::op_u_lui:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.lui      = 1'b1;
        imm           = imm_u;
      end
      rv_pkg::op_u_auipc:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.auipc    = 1'b1;
        imm           = imm_u;
      end
      default: ;
    endcase
  end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                          clk,
  input  logic                          reset,
  input  rv_pkg::wb_t                   wb,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [0:31];
  logic                    wr_en;

  assign wr_en = wb.we && (wb.rd != '0);   // x0 never written, stays zero

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      regs <= '{default: '0};
    else if (wr_en)
      regs[wb.rd] <= wb.data;
  end

  // Write-through covers the WB to ID case in the same cycle
  assign rs1_data = (wr_en && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2_data = (wr_en && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic           clk,
  input  logic           reset,
  input  rv_pkg::if_id_t if_id,
  input  rv_pkg::wb_t    wb,       // Write port from write-back
  output logic           stall,
  output rv_pkg::id_ex_t id_ex
);

  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::xlen-1:0]       rs1_data;
  logic [rv_pkg::xlen-1:0]       rs2_data;
  logic [rv_pkg::xlen-1:0]       imm;
  rv_pkg::ctrl_t                 ctrl;

  // Register fields
  assign rs1 = if_id.inst[19:15];
  assign rs2 = if_id.inst[24:20];
  assign rd  = if_id.inst[11:7];

  inst_decoder u_inst_decoder (
    .inst (if_id.inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .wb       (wb),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  ////////////////////
  // Load-use hazard
  ////////////////////
  // Load data only exists after MEM and comes too late for EX forwarding
  assign stall = id_ex.ctrl.memtoreg && (id_ex.rd != '0) &&
                 ((id_ex.rd == rs1) || (id_ex.rd == rs2));

  ////////////////////
  // ID/EX register
  ////////////////////
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex.ctrl <= '0;          // No-op controls
    else if (stall)
      id_ex <= '0;               // Bubble with all controls off and x0 indices
    else
      id_ex <= '{
        pc:       if_id.pc,
        rs1:      rs1,
        rs2:      rs2,
        rd:       rd,
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm:      imm,
        ctrl:     ctrl
      };
  end

  // Stalled instruction must still sit in the fetch register next cycle
  a_fetch_held: assert property (
    @(posedge clk) disable iff (reset)
    stall |=> $stable(if_id)
  ) else $error("fetch register changed during a load-use stall");

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::id_ex_t  id_ex,
  input  rv_pkg::wb_t     wb,        // Write-back forwarding source
  output rv_pkg::ex_mem_t ex_mem
);

  logic [rv_pkg::xlen-1:0] rs1_fwd;
  logic [rv_pkg::xlen-1:0] rs2_fwd;   // Also the store data
  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] op_b;
  logic [rv_pkg::xlen-1:0] aluout;

  ////////////////////
  // Forwarding
  ////////////////////
  // MEM result first (newest), then WB, then the decode read
  function automatic logic [rv_pkg::xlen-1:0] fwd_operand(
    input logic [rv_pkg::reg_addr_w-1:0] rs,
    input logic [rv_pkg::xlen-1:0]       rf_val
  );
    logic mem_hit;
    logic wb_hit;
    mem_hit = ex_mem.regwrite && !ex_mem.memtoreg &&    // Load data not ready here
              (ex_mem.rd != '0) && (ex_mem.rd == rs);
    wb_hit  = wb.we && (wb.rd != '0) && (wb.rd == rs);
    if (mem_hit)
      return ex_mem.aluout;
    else if (wb_hit)
      return wb.data;
    else
      return rf_val;
  endfunction

  always_comb
  begin
    rs1_fwd = fwd_operand(id_ex.rs1, id_ex.rs1_data);
    rs2_fwd = fwd_operand(id_ex.rs2, id_ex.rs2_data);
  end

  // Operand select
  always_comb
  begin
    if (id_ex.ctrl.auipc)
      op_a = id_ex.pc;          // AUIPC adds its own pc
    else if (id_ex.ctrl.lui)
      op_a = '0;                // LUI is 0 + imm
    else
      op_a = rs1_fwd;
    op_b = id_ex.ctrl.alusrc ? id_ex.imm : rs2_fwd;
  end

  ////////////////////
  // ALU
  ////////////////////
  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      rv_pkg::alu_add: aluout = op_a + op_b;
      rv_pkg::alu_sub: aluout = op_a - op_b;
      rv_pkg::alu_and: aluout = op_a & op_b;
      rv_pkg::alu_or:  aluout = op_a | op_b;
      rv_pkg::alu_xor: aluout = op_a ^ op_b;
      rv_pkg::alu_sll: aluout = op_a << op_b[4:0];   // shamt, low five bits
      default:         aluout = '0;
    endcase
  end

  // EX/MEM register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex_mem.regwrite <= 1'b0;
      ex_mem.memtoreg <= 1'b0;
      ex_mem.memwrite <= 1'b0;
    end
    else
    begin
      ex_mem.rd         <= id_ex.rd;
      ex_mem.aluout     <= aluout;
      ex_mem.store_data <= rs2_fwd;
      ex_mem.regwrite   <= id_ex.ctrl.regwrite;
      ex_mem.memtoreg   <= id_ex.ctrl.memtoreg;
      ex_mem.memwrite   <= id_ex.ctrl.memwrite;
    end
  end

  // Decode must have stalled any reader sitting right behind a load
  a_no_load_use: assert property (
    @(posedge clk) disable iff (reset)
    !(ex_mem.memtoreg && (ex_mem.rd != '0) &&
      ((id_ex.rs1 == ex_mem.rd) || (id_ex.rs2 == ex_mem.rd)))
  ) else $error("load-use hazard reached execute");

endmodule

// File: hw/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::ex_mem_t         ex_mem,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,   // Combinational read
  output logic                    mem_write,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output rv_pkg::wb_t             wb
);

  ////////////////////
  // Data port
  ////////////////////
  assign mem_write = ex_mem.memwrite;   // Store lands on the next edge
  assign mem_addr  = ex_mem.aluout;
  assign mem_wdata = ex_mem.store_data;

  // MEM/WB register, write-back value picked before the flop
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      wb.we <= 1'b0;
    else
    begin
      wb.we   <= ex_mem.regwrite;
      wb.rd   <= ex_mem.rd;
      wb.data <= ex_mem.memtoreg ? mem_rdata : ex_mem.aluout;   // Load or ALU
    end
  end

endmodule

// File: hw/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core (
  input  logic                    clk,
  input  logic                    reset,
  output logic [rv_pkg::xlen-1:0] pc,          // Instruction fetch address
  input  logic [rv_pkg::xlen-1:0] inst,        // Valid for current pc
  output logic                    mem_write,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  input  logic [rv_pkg::xlen-1:0] mem_rdata
);

  rv_pkg::if_id_t  if_id;
  rv_pkg::id_ex_t  id_ex;
  rv_pkg::ex_mem_t ex_mem;
  rv_pkg::wb_t     wb;       // Back to decode and execute
  logic            stall;

  ////////////////////
  // Stages
  ////////////////////
  fetch_stage u_fetch (
    .clk   (clk),
    .reset (reset),
    .stall (stall),
    .inst  (inst),
    .pc    (pc),
    .if_id (if_id)
  );

  decode_stage u_decode (
    .clk   (clk),
    .reset (reset),
    .if_id (if_id),
    .wb    (wb),
    .stall (stall),
    .id_ex (id_ex)
  );

  execute_stage u_execute (
    .clk    (clk),
    .reset  (reset),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .mem_rdata (mem_rdata),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .wb        (wb)
  );

endmodule

// File: verif/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Data memory fill, every bit pattern tied to the whole index
function automatic logic [31:0] fill_word(input logic [5:0] idx);
  return {idx, 2'b01, ~idx, 2'b10, idx, 2'b11, ~idx, 2'b00};
endfunction

////////////////////
// Program generator
////////////////////
// One random non-load instruction, registers x0..x7 only
task automatic random_inst(output logic [31:0] w);
  logic [31:0] r;
  logic [31:0] f;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  r   = $random(seed);
  f   = $random(seed);
  rd  = {2'b00, f[2:0]};
  rs1 = {2'b00, f[5:3]};
  rs2 = {2'b00, f[8:6]};
  case (r % 32'd12)
    32'd0:   w = {7'b0000000, rs2, rs1, 3'b000, rd, rv_pkg::op_r};         // ADD
    32'd1:   w = {7'b0100000, rs2, rs1, 3'b000, rd, rv_pkg::op_r};         // SUB
    32'd2:   w = {7'b0000000, rs2, rs1, 3'b111, rd, rv_pkg::op_r};         // AND
    32'd3:   w = {7'b0000000, rs2, rs1, 3'b110, rd, rv_pkg::op_r};         // OR
    32'd4:   w = {f[31:20], rs1, 3'b000, rd, rv_pkg::op_i_arith};          // ADDI
    32'd5:   w = {f[31:20], rs1, 3'b100, rd, rv_pkg::op_i_arith};          // XORI
    32'd6:   w = {f[31:20], rs1, 3'b110, rd, rv_pkg::op_i_arith};          // ORI
    32'd7:   w = {f[31:20], rs1, 3'b111, rd, rv_pkg::op_i_arith};          // ANDI
    32'd8:   w = {7'b0, f[24:20], rs1, 3'b001, rd, rv_pkg::op_i_arith};    // SLLI
    32'd9:   w = {f[31:12], rd, rv_pkg::op_u_lui};
    32'd10:  w = {f[31:12], rd, rv_pkg::op_u_auipc};
    default: w = {4'b0, f[17:15], rs2, 5'd0, 3'b010, f[14:12], 2'b00, rv_pkg::op_s}; // SW
  endcase
endtask

task automatic generate_program();
  logic [31:0] r;
  logic [31:0] f;
  logic [31:0] w;
  logic [4:0]  rd;
  int          i;
  for (int k = 0; k < 256; k++)
    imem[k[7:0]] = 32'h0000_0013;                   // ADDI x0, x0, 0
  i = 0;
  while (i < body_len)
  begin
    r = $random(seed);
    f = $random(seed);
    if (r[3:0] < 4'd3)
    begin
      rd = {2'b00, f[2:0]};
      imem[i[7:0]] = {4'b0, f[17:12], 2'b00, 5'd0, 3'b010, rd, rv_pkg::op_i_load}; // LW
      i++;
      if (r[4] && i < body_len)                     // Planted reader right behind
      begin
        if (r[5])
          imem[i[7:0]] = {4'b0, f[25:23], rd, 5'd0, 3'b010, f[22:20], 2'b00, rv_pkg::op_s};
        else
          imem[i[7:0]] = {7'b0, 2'b00, f[8:6], rd, 3'b000, 2'b00, f[11:9], rv_pkg::op_r};
        i++;
      end
    end
    else
    begin
      random_inst(w);
      imem[i[7:0]] = w;
      i++;
    end
  end
  // Tail, SW xk to 224 + 4k so every final register is seen
  for (int k = 0; k < 8; k++)
  begin
    imem[i[7:0]] = {7'b0000111, 2'b00, k[2:0], 5'd0, 3'b010, k[2:0], 2'b00, rv_pkg::op_s};
    i++;
  end
  prog_len = i;
endtask

////////////////////
// Instruction-level model
////////////////////
task automatic run_model();
  logic [31:0] x [0:31];
  logic [31:0] dm [0:63];
  logic [31:0] w;
  logic [31:0] ipc;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] addr;
  logic [31:0] res;
  logic        wr;
  logic        prev_load;
  logic [4:0]  prev_rd;
  for (int k = 0; k < 32; k++)
    x[k[4:0]] = '0;
  for (int k = 0; k < 64; k++)
    dm[k[5:0]] = fill_word(k[5:0]);
  for (int k = 0; k < 256; k++)
    stall_at[k[7:0]] = 1'b0;
  prev_load = 1'b0;
  prev_rd   = '0;
  stall_cnt = 0;
  for (int i = 0; i < prog_len; i++)
  begin
    w     = imem[i[7:0]];
    ipc   = {i[29:0], 2'b00};
    a     = x[w[19:15]];
    b     = x[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    // Decode holds one cycle when the field names a load's rd
    stall_at[i[7:0]] = prev_load && (prev_rd != 5'd0) &&
                       ((w[19:15] == prev_rd) || (w[24:20] == prev_rd));
    if (stall_at[i[7:0]])
      stall_cnt++;
    prev_load = (w[6:0] == rv_pkg::op_i_load);
    prev_rd   = w[11:7];
    wr  = 1'b1;
    res = '0;
    case (w[6:0])
      rv_pkg::op_r:
        case (w[14:12])
          3'b000:  res = w[30] ? a - b : a + b;     // SUB when funct7 bit 5
          3'b111:  res = a & b;
          default: res = a | b;
        endcase
      rv_pkg::op_i_arith:
        case (w[14:12])
          3'b000:  res = a + imm_i;
          3'b100:  res = a ^ imm_i;
          3'b110:  res = a | imm_i;
          3'b111:  res = a & imm_i;
          default: res = a << w[24:20];
        endcase
      rv_pkg::op_i_load:
      begin
        addr = a + imm_i;
        res  = dm[addr[7:2]];
      end
      rv_pkg::op_s:
      begin
        wr   = 1'b0;
        addr = a + imm_s;
        dm[addr[7:2]] = b;
        exp_addr.push_back(addr);                   // Ordered store list
        exp_data.push_back(b);
      end
      rv_pkg::op_u_lui:   res = {w[31:12], 12'b0};
      rv_pkg::op_u_auipc: res = ipc + {w[31:12], 12'b0};   // Own pc
      default:            wr = 1'b0;
    endcase
    if (wr && (w[11:7] != 5'd0))                    // x0 stays zero
      x[w[11:7]] = res;
  end
endtask

`endif

// File: verif/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  localparam int body_len = 140;      // Random part before the eight tail stores

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  logic [31:0] imem [0:255];          // Program followed by ADDI x0 no-ops
  logic [31:0] dmem [0:63];
  logic        stall_at [0:255];      // Instruction holds in decode
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  integer      seed;
  int          prog_len;
  int          stall_cnt;
  logic        running = 1'b0;        // Starts the watchdog

  `include "isa_model.svh"

  rv32i_core dut0 (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Memories
  ////////////////////
  assign inst      = imem[pc[9:2]];          // Combinational fetch
  assign mem_rdata = dmem[mem_addr[7:2]];

  always @(posedge clk or posedge reset)
  begin
    if (reset)
      for (int k = 0; k < 64; k++)
        dmem[k[5:0]] <= fill_word(k[5:0]);
    else if (mem_write)
      dmem[mem_addr[7:2]] <= mem_wdata;      // Store lands at the edge
  end

  ////////////////////
  // Reporting
  ////////////////////
  task automatic stop_run(input string reason);
    $display("Checks failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      stop_run("Run stopped at the first mismatch");
    end
  endtask

  // Drain bound from program length and pipeline depth with twice the stalls as margin
  initial
  begin : watchdog
    wait (running);
    repeat (prog_len + 20 + 2 * stall_cnt) @(posedge clk);
    stop_run("Timeout, the program did not drain through the pipeline");
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin : main
    logic [31:0] exp_pc;
    logic [31:0] end_pc;
    logic        held;
    logic        done;
    int          n_obs;
    reset       <= 1'b1;
    seed        = 32'hfe4c4b56;
    generate_program();
    run_model();
    end_pc = (prog_len + 4) * 4;             // Last instruction past write-back
    repeat (3)
    begin
      @(negedge clk);
      check_value("pc", pc, 32'd0);
      check_value("mem_write", {31'd0, mem_write}, 32'd0);   // Quiet in reset
    end
    @(posedge clk);
    reset   <= 1'b0;                         // Four reset edges seen
    running = 1'b1;
    exp_pc  = '0;
    held    = 1'b0;
    done    = 1'b0;
    n_obs   = 0;
    while (!done)
    begin
      @(negedge clk);                        // Outputs settled
      check_value("pc", pc, exp_pc);
      if (mem_write)
      begin
        if (n_obs >= exp_addr.size())
          stop_run("Store seen after the last expected store");
        check_value("mem_addr", mem_addr, exp_addr[n_obs]);
        check_value("mem_wdata", mem_wdata, exp_data[n_obs]);
        n_obs++;
      end
      if (exp_pc == end_pc)
        done = 1'b1;
      else if (!held && (exp_pc[9:2] != 8'd0) && stall_at[exp_pc[9:2] - 8'd1])
        held = 1'b1;                         // Load-use holds the same pc once more
      else
      begin
        exp_pc = exp_pc + 32'd4;
        held   = 1'b0;
      end
    end
    if (n_obs == exp_addr.size())
    begin
      $display("All checks passed");
      $finish;
    end
    else
      check_value("store_count", n_obs, exp_addr.size());
  end

endmodule

// File: list.f
+incdir+verif
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/rv32i_core.sv
verif/tb_core.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP   = tb_core
FLIST = list.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
